// ==== flitPkg.sv ====
`default_nettype none

package flitPkg;

  // flit kind, one-hot coded.
  typedef logic [2:0] flitIdT;

  // packet timeout in clock cycles, carried by the header flit.
  typedef logic [11:0] pktLengthT;

  // the header is the only flit whose length field is meaningful.
  localparam flitIdT HeadFlitId = 3'b001;
  localparam flitIdT BodyFlitId = 3'b010;
  localparam flitIdT TailFlitId = 3'b100;

endpackage : flitPkg

`default_nettype wire

// ==== arbPkg.sv ====
`default_nettype none

package arbPkg;

  // the rotation order names the ports, so the count is fixed.
  localparam int NumPorts = 5;

  typedef logic [2:0] portIdxT;

  localparam portIdxT PortL = 3'd0;
  localparam portIdxT PortN = 3'd1;
  localparam portIdxT PortE = 3'd2;
  localparam portIdxT PortW = 3'd3;
  localparam portIdxT PortS = 3'd4;

  // one-hot per port, bit index is the port index.
  typedef logic [NumPorts-1:0] grantVecT;

  // bit 0 is idle, bits 1..5 grant L, N, E, W, S.
  typedef enum logic [5:0] {
    ArbIdle = 6'b000001,
    GrantL  = 6'b000010,
    GrantN  = 6'b000100,
    GrantE  = 6'b001000,
    GrantW  = 6'b010000,
    GrantS  = 6'b100000
  } arbStateT;

endpackage : arbPkg

`default_nettype wire

// ==== inputSlot.sv ====
`timescale 1ns/1ps
`default_nettype none

module inputSlot
  import flitPkg::*;
#(
  parameter int DataWidth = 16
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 inReq,
  input  flitIdT               inFlitId,
  input  pktLengthT            inLength,
  input  logic [DataWidth-1:0] inData,
  input  logic                 runTimer,
  input  logic                 take,
  output logic                 inAck,
  output logic                 pending,
  output logic                 timesUp,
  output flitIdT               flitId,
  output pktLengthT            length,
  output logic [DataWidth-1:0] data
);

  pktLengthT timeout;
  pktLengthT count;
  logic      capture;

  // accept only into an empty slot, and only once per request.
  // a full slot leaves inAck low, which stalls the sender.
  assign capture = inReq && !inAck && !pending;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      inAck   <= 1'b0;
      pending <= 1'b0;
    end
    else
    begin
      if (capture)
        inAck <= 1'b1;
      else if (!inReq)
        inAck <= 1'b0;

      if (capture)
        pending <= 1'b1;
      else if (take)
        pending <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (capture)
    begin
      flitId <= inFlitId;
      length <= inLength;
      data   <= inData;
    end
  end

  // packet timer.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      timeout <= '0;
      count   <= '0;
    end
    else
    begin
      if (capture && inFlitId == HeadFlitId)
        timeout <= inLength;

      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // a zero timeout means the owner never keeps the grant past one decision.
  assign timesUp = (count == timeout);

endmodule : inputSlot

`default_nettype wire

// ==== outputArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module outputArbiter
  import arbPkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  grantVecT pending,
  input  grantVecT timesUp,
  output grantVecT grant,
  output grantVecT runTimer
);

  arbStateT state;
  arbStateT nextState;
  portIdxT  owner;

  function automatic arbStateT grantState(portIdxT idx);
    return arbStateT'(6'b000010 << idx);
  endfunction

  // first pending port after last, wrapping round to last itself.
  function automatic arbStateT pickNext(grantVecT req, portIdxT last);
    portIdxT idx;
    pickNext = ArbIdle;
    // walk from the far end so the nearest pending port wins.
    for (int i = NumPorts; i >= 1; i--)
    begin
      idx = portIdxT'((int'(last) + i) % NumPorts);
      if (req[idx])
        pickNext = grantState(idx);
    end
  endfunction

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= ArbIdle;
    else
      state <= nextState;
  end

  always_comb
  begin
    unique case (state)
      GrantN:  owner = PortN;
      GrantE:  owner = PortE;
      GrantW:  owner = PortW;
      GrantS:  owner = PortS;
      default: owner = PortL;
    endcase
  end

  always_comb
  begin
    nextState = ArbIdle;
    runTimer  = '0;
    if (state == ArbIdle)
    begin
      // search starts after S, so L has the highest priority.
      nextState = pickNext(pending, PortS);
    end
    else if (pending[owner] && !timesUp[owner])
    begin
      nextState       = state;
      runTimer[owner] = 1'b1;
    end
    else
    begin
      nextState = pickNext(pending, owner);
    end
  end

  assign grant = state[NumPorts:1];

endmodule : outputArbiter

`default_nettype wire

// ==== outputLink.sv ====
`timescale 1ns/1ps
`default_nettype none

module outputLink
  import flitPkg::*;
  import arbPkg::*;
#(
  parameter int DataWidth = 16
) (
  input  logic                                clk,
  input  logic                                rst,
  input  grantVecT                            grant,
  input  grantVecT                            pending,
  input  flitIdT    [NumPorts-1:0]            slotFlitId,
  input  pktLengthT [NumPorts-1:0]            slotLength,
  input  logic      [NumPorts-1:0][DataWidth-1:0] slotData,
  input  logic                                outAck,
  output grantVecT                            take,
  output logic                                outReq,
  output flitIdT                              outFlitId,
  output pktLengthT                           outLength,
  output logic      [DataWidth-1:0]           outData,
  output portIdxT                             outSrc
);

  typedef enum logic [1:0] {
    LinkIdle,
    LinkReq,
    LinkRelease
  } linkStateT;

  linkStateT linkState;
  portIdxT   selIdx;
  logic      load;

  // grant is one-hot, so the last set bit is the only one.
  always_comb
  begin
    selIdx = '0;
    for (int p = 0; p < NumPorts; p++)
    begin
      if (grant[p])
        selIdx = portIdxT'(p);
    end
  end

  assign take = (linkState == LinkIdle) ? (grant & pending) : '0;
  assign load = |take;

  always_ff @(posedge clk)
  begin
    if (rst)
      linkState <= LinkIdle;
    else
    begin
      unique case (linkState)
        LinkIdle:    if (load) linkState <= LinkReq;
        LinkReq:     if (outAck) linkState <= LinkRelease;
        LinkRelease: if (!outAck) linkState <= LinkIdle;
        default:     linkState <= LinkIdle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      outFlitId <= slotFlitId[selIdx];
      outLength <= slotLength[selIdx];
      outData   <= slotData[selIdx];
      outSrc    <= selIdx;
    end
  end

  assign outReq = (linkState == LinkReq);

endmodule : outputLink

`default_nettype wire

// ==== routerOutputPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort
  import flitPkg::*;
  import arbPkg::*;
#(
  parameter int DataWidth = 16
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic      [NumPorts-1:0]            inReq,
  output logic      [NumPorts-1:0]            inAck,
  input  flitIdT    [NumPorts-1:0]            inFlitId,
  input  pktLengthT [NumPorts-1:0]            inLength,
  input  logic      [NumPorts-1:0][DataWidth-1:0] inData,
  output logic                                outReq,
  input  logic                                outAck,
  output flitIdT                              outFlitId,
  output pktLengthT                           outLength,
  output logic      [DataWidth-1:0]           outData,
  output portIdxT                             outSrc
);

  grantVecT                            pending;
  grantVecT                            timesUp;
  grantVecT                            grant;
  grantVecT                            runTimer;
  grantVecT                            take;
  flitIdT    [NumPorts-1:0]            slotFlitId;
  pktLengthT [NumPorts-1:0]            slotLength;
  logic      [NumPorts-1:0][DataWidth-1:0] slotData;

  outputArbiter i_outputArbiter (
    .clk      (clk),
    .rst      (rst),
    .pending  (pending),
    .timesUp  (timesUp),
    .grant    (grant),
    .runTimer (runTimer)
  );

  for (genvar p = 0; p < NumPorts; p++)
  begin : g_slot
    inputSlot #(
      .DataWidth (DataWidth)
    ) i_inputSlot (
      .clk      (clk),
      .rst      (rst),
      .inReq    (inReq[p]),
      .inFlitId (inFlitId[p]),
      .inLength (inLength[p]),
      .inData   (inData[p]),
      .runTimer (runTimer[p]),
      .take     (take[p]),
      .inAck    (inAck[p]),
      .pending  (pending[p]),
      .timesUp  (timesUp[p]),
      .flitId   (slotFlitId[p]),
      .length   (slotLength[p]),
      .data     (slotData[p])
    );
  end

  outputLink #(
    .DataWidth (DataWidth)
  ) i_outputLink (
    .clk        (clk),
    .rst        (rst),
    .grant      (grant),
    .pending    (pending),
    .slotFlitId (slotFlitId),
    .slotLength (slotLength),
    .slotData   (slotData),
    .outAck     (outAck),
    .take       (take),
    .outReq     (outReq),
    .outFlitId  (outFlitId),
    .outLength  (outLength),
    .outData    (outData),
    .outSrc     (outSrc)
  );

endmodule : routerOutputPort

`default_nettype wire

// ==== routerOutputPort_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort_checker
  import arbPkg::*;
(
  input logic     clk,
  input logic     rst,
  input grantVecT grant,
  input grantVecT pending,
  input grantVecT take,
  input logic     outReq,
  input logic     outAck
);

  // at most one owner at a time.
  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("grant is neither one-hot nor zero");

  // four-phase sender keeps req up until ack arrives.
  reqHeld: assert property (@(posedge clk) disable iff (rst) outReq && !outAck |=> outReq)
    else $error("outReq fell before outAck rose");

  takeOneHot: assert property (@(posedge clk) disable iff (rst) $onehot0(take))
    else $error("take names more than one slot");

  // a taken slot is empty on the following cycle.
  takeEmpties: assert property (@(posedge clk) disable iff (rst)
    (take != '0) |=> (pending & $past(take)) == '0)
    else $error("take did not empty its slot");

endmodule : routerOutputPort_checker

bind outputLink routerOutputPort_checker i_linkChecker (
  .clk     (clk),
  .rst     (rst),
  .grant   (grant),
  .pending (pending),
  .take    (take),
  .outReq  (outReq),
  .outAck  (outAck)
);

`default_nettype wire

// ==== routerOutputPort_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort_tb
  import flitPkg::*;
  import arbPkg::*;
();

  localparam int DataWidth = 16;
  localparam int FlitBits = 3 + 12 + DataWidth;
  localparam int TimeoutCycles = 2000;

  logic                               clk = 1'b0;
  logic                               rst;
  logic      [NumPorts-1:0]           inReq;
  logic      [NumPorts-1:0]           inAck;
  flitIdT    [NumPorts-1:0]           inFlitId;
  pktLengthT [NumPorts-1:0]           inLength;
  logic      [NumPorts-1:0][DataWidth-1:0] inData;
  logic                               outReq;
  logic                               outAck;
  flitIdT                             outFlitId;
  pktLengthT                          outLength;
  logic      [DataWidth-1:0]          outData;
  portIdxT                            outSrc;

  int seed = 32'h5219_db3b;
  int errorCount = 0;
  int checkCount = 0;
  int testCount = 0;

  // flits still expected per port, packed as {id, length, data}.
  logic [FlitBits-1:0] sentQ[NumPorts][$];
  portIdxT             gotSrc[$];

  routerOutputPort #(
    .DataWidth (DataWidth)
  ) i_routerOutputPort (
    .clk       (clk),
    .rst       (rst),
    .inReq     (inReq),
    .inAck     (inAck),
    .inFlitId  (inFlitId),
    .inLength  (inLength),
    .inData    (inData),
    .outReq    (outReq),
    .outAck    (outAck),
    .outFlitId (outFlitId),
    .outLength (outLength),
    .outData   (outData),
    .outSrc    (outSrc)
  );

  always #5 clk = ~clk;

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checkCount++;
    if (got !== exp)
    begin
      errorCount++;
      $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic reportTimeout(input string what);
    errorCount++;
    $display("%0t ns: timed out waiting for %s", $time, what);
  endtask

  task automatic sendFlit(input int port, input flitIdT id, input pktLengthT len,
                          input logic [DataWidth-1:0] d);
    int waitCnt;
    @(negedge clk);
    sentQ[port].push_back({id, len, d});
    inFlitId[port] = id;
    inLength[port] = len;
    inData[port]   = d;
    inReq[port]    = 1'b1;
    waitCnt = 0;
    while (!inAck[port] && waitCnt < TimeoutCycles)
    begin
      @(negedge clk);
      waitCnt++;
    end
    if (!inAck[port])
      reportTimeout($sformatf("inAck to rise on port %0d", port));
    inReq[port] = 1'b0;
    waitCnt = 0;
    while (inAck[port] && waitCnt < TimeoutCycles)
    begin
      @(negedge clk);
      waitCnt++;
    end
    if (inAck[port])
      reportTimeout($sformatf("inAck to fall on port %0d", port));
  endtask

  // header first, tail last, one flit alone is a header.
  task automatic sendPacket(input int port, input int numFlits, input pktLengthT len);
    flitIdT id;
    for (int i = 0; i < numFlits; i++)
    begin
      if (i == 0)
        id = HeadFlitId;
      else if (i == numFlits - 1)
        id = TailFlitId;
      else
        id = BodyFlitId;
      sendFlit(port, id, len, DataWidth'($random(seed)));
    end
  endtask

  task automatic receiveFlit(input int ackDelay);
    int                  waitCnt;
    logic [FlitBits-1:0] expFlit;
    @(negedge clk);
    waitCnt = 0;
    while (!outReq && waitCnt < TimeoutCycles)
    begin
      @(negedge clk);
      waitCnt++;
    end
    if (!outReq)
    begin
      reportTimeout("outReq to rise");
      return;
    end
    gotSrc.push_back(outSrc);
    if (outSrc >= NumPorts || sentQ[outSrc].size() == 0)
    begin
      errorCount++;
      $display("%0t ns: flit from port %0d arrived without a matching send", $time, outSrc);
    end
    else
    begin
      expFlit = sentQ[outSrc].pop_front();
      checkValue("outFlitId", outFlitId, expFlit[FlitBits-1 -: 3]);
      checkValue("outLength", outLength, expFlit[DataWidth +: 12]);
      checkValue("outData", outData, expFlit[DataWidth-1:0]);
    end
    repeat (ackDelay) @(negedge clk);
    outAck = 1'b1;
    waitCnt = 0;
    while (outReq && waitCnt < TimeoutCycles)
    begin
      @(negedge clk);
      waitCnt++;
    end
    if (outReq)
      reportTimeout("outReq to fall");
    outAck = 1'b0;
  endtask

  task automatic clearRecords();
    gotSrc.delete();
    for (int p = 0; p < NumPorts; p++)
      sentQ[p].delete();
  endtask

  task automatic checkAllDelivered();
    for (int p = 0; p < NumPorts; p++)
      checkValue($sformatf("undelivered flits on port %0d", p), sentQ[p].size(), 0);
  endtask

  task automatic finishTest(input string name, input int errorsBefore);
    testCount++;
    if (errorCount == errorsBefore)
      $display("test %s: ok", name);
    else
      $display("test %s: %0d errors", name, errorCount - errorsBefore);
  endtask

  task automatic testResetState();
    int   errs;
    logic seenReq;
    errs = errorCount;
    seenReq = 1'b0;
    checkValue("inAck", inAck, 0);
    repeat (20)
    begin
      @(negedge clk);
      seenReq = seenReq | outReq;
    end
    checkValue("outReq", seenReq, 0);
    checkValue("inAck", inAck, 0);
    finishTest("resetState", errs);
  endtask

  task automatic testSinglePort();
    int errs;
    errs = errorCount;
    clearRecords();
    fork
      sendPacket(PortN, 5, 12'd20);
      repeat (5) receiveFlit(0);
    join
    checkValue("flit count", gotSrc.size(), 5);
    foreach (gotSrc[i])
      checkValue("outSrc", gotSrc[i], PortN);
    checkAllDelivered();
    finishTest("singlePort", errs);
  endtask

  task automatic testRotation();
    int errs;
    errs = errorCount;
    clearRecords();
    // a long timeout keeps each owner until its slot is taken.
    fork
      sendPacket(PortL, 1, 12'd400);
      sendPacket(PortN, 1, 12'd400);
      sendPacket(PortE, 1, 12'd400);
      sendPacket(PortW, 1, 12'd400);
      sendPacket(PortS, 1, 12'd400);
    join
    repeat (NumPorts) receiveFlit(0);
    checkValue("flit count", gotSrc.size(), NumPorts);
    foreach (gotSrc[i])
      checkValue("outSrc order", gotSrc[i], i);
    checkAllDelivered();
    finishTest("rotation", errs);
  endtask

  task automatic testTimeoutFairness();
    int errs;
    int southIdx;
    int eastLast;
    errs = errorCount;
    clearRecords();
    fork
      sendPacket(PortE, 8, 12'd2);
      begin
        repeat (4) @(negedge clk);
        sendPacket(PortS, 1, 12'd400);
      end
      repeat (9) receiveFlit(2);
    join
    southIdx = -1;
    eastLast = -1;
    foreach (gotSrc[i])
    begin
      if (gotSrc[i] == PortS)
        southIdx = i;
      if (gotSrc[i] == PortE)
        eastLast = i;
    end
    checkValue("flit count", gotSrc.size(), 9);
    checkValue("south before east tail", (southIdx >= 0) && (southIdx < eastLast), 1);
    checkAllDelivered();
    finishTest("timeoutFairness", errs);
  endtask

  task automatic testBackPressure();
    int errs;
    errs = errorCount;
    clearRecords();
    fork
      sendPacket(PortL, 4, 12'd3);
      sendPacket(PortN, 4, 12'd3);
      sendPacket(PortE, 4, 12'd3);
      sendPacket(PortW, 4, 12'd3);
      sendPacket(PortS, 4, 12'd3);
      repeat (4 * NumPorts) receiveFlit(12);
    join
    checkValue("flit count", gotSrc.size(), 4 * NumPorts);
    checkAllDelivered();
    finishTest("backPressure", errs);
  endtask

  initial
  begin
    rst      = 1'b1;
    inReq    = '0;
    inFlitId = '0;
    inLength = '0;
    inData   = '0;
    outAck   = 1'b0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    testResetState();
    testSinglePort();
    testRotation();
    testTimeoutFairness();
    testBackPressure();
    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule : routerOutputPort_tb

`default_nettype wire

// ==== routerOutputPort.f ====
flitPkg.sv
arbPkg.sv
inputSlot.sv
outputArbiter.sv
outputLink.sv
routerOutputPort.sv
routerOutputPort_checker.sv
routerOutputPort_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= routerOutputPort_tb
DUT_TOP    ?= routerOutputPort
FILELIST   ?= routerOutputPort.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
